//--- src/tracker_pkg.sv
package tracker_pkg;

  // pixel coordinate widths for a 1280x720 frame
  localparam int HCOUNT_W = 11;
  localparam int VCOUNT_W = 10;

  // one colour or chroma channel after widening
  localparam int CHAN_W = 8;

  // coordinate sums and hit count
  // worst case 1280*720 hits at hcount 1279 is still below 2^32
  localparam int SUM_W = 32;

  // pixel in to mask bit out
  // widen, multiply, sum, compare
  localparam int DETECT_LATENCY = 4;

  // rgb565 word from the camera
  // raw view for the bus, field view for the colour math
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      // msb end of the word
      logic [4:0] red;
      logic [5:0] green;
      // lsb end
      logic [4:0] blue;
    } fields;
  } pixel565_u;

endpackage

//--- src/mask_if.sv
`timescale 1ns/10ps

// mask bits with their pixel coordinates, already aligned by the detector
interface mask_if import tracker_pkg::*; ();

  logic                valid;
  logic [HCOUNT_W-1:0] hcount;
  logic [VCOUNT_W-1:0] vcount;
  // one hit per target colour with red on cr and blue on cb
  logic                cr_hit;
  logic                cb_hit;
  // one-cycle pulse that always follows the last pixel mask of a frame
  logic                frame_end;

  // detector side
  modport src (
    output valid, hcount, vcount, cr_hit, cb_hit, frame_end
  );

  // accumulator side shared by both trackers
  modport dst (
    input valid, hcount, vcount, cr_hit, cb_hit, frame_end
  );

endinterface

//--- src/chroma_detect.sv
`timescale 1ns/10ps

module chroma_detect import tracker_pkg::*; #(
  parameter logic [CHAN_W-1:0] CR_LOW  = 8'd160,
  parameter logic [CHAN_W-1:0] CR_HIGH = 8'd240,
  parameter logic [CHAN_W-1:0] CB_LOW  = 8'd160,
  parameter logic [CHAN_W-1:0] CB_HIGH = 8'd240
) (
  input  logic                clk_camera,
  input  logic                sys_rst_pixel,
  input  logic                pixel_valid_i,
  input  logic [HCOUNT_W-1:0] pixel_hcount_i,
  input  logic [VCOUNT_W-1:0] pixel_vcount_i,
  input  pixel565_u           pixel_data_i,
  input  logic                frame_end_i,
  mask_if.src                 mask_o
);

  // the largest product 112*255 fits in 15 bits unsigned
  localparam int PROD_W = 15;
  // room for the sign and one subtract
  localparam int ACC_W = PROD_W + 2;

  // stage 1 holds the channels widened to 8 bits
  logic [CHAN_W-1:0] red_s1;
  logic [CHAN_W-1:0] green_s1;
  logic [CHAN_W-1:0] blue_s1;
  // stage 2 holds the coefficient products
  // signs are applied in the next stage
  logic [PROD_W-1:0] cr_r_s2;
  logic [PROD_W-1:0] cr_g_s2;
  logic [PROD_W-1:0] cr_b_s2;
  logic [PROD_W-1:0] cb_r_s2;
  logic [PROD_W-1:0] cb_g_s2;
  logic [PROD_W-1:0] cb_b_s2;
  logic signed [ACC_W-1:0] cr_sum;
  logic signed [ACC_W-1:0] cb_sum;
  logic signed [ACC_W-1:0] cr_shift;
  logic signed [ACC_W-1:0] cb_shift;
  // stage 3 holds chroma with the 128 offset
  logic [CHAN_W-1:0] cr_s3;
  logic [CHAN_W-1:0] cb_s3;
  // stage 4 holds the bound compares
  logic cr_hit_s4;
  logic cb_hit_s4;
  // sideband delay lines with one entry per stage
  logic [DETECT_LATENCY-1:0] valid_pipe;
  logic [DETECT_LATENCY-1:0] frame_end_pipe;
  logic [HCOUNT_W-1:0]       hcount_pipe [DETECT_LATENCY];
  logic [VCOUNT_W-1:0]       vcount_pipe [DETECT_LATENCY];

  // widen each field by zero-filling its low bits
  always_ff @(posedge clk_camera) begin
    red_s1   <= {pixel_data_i.fields.red, 3'b000};
    green_s1 <= {pixel_data_i.fields.green, 2'b00};
    blue_s1  <= {pixel_data_i.fields.blue, 3'b000};
  end

  always_ff @(posedge clk_camera) begin
    // cr = 112r - 94g - 18b
    cr_r_s2 <= PROD_W'(red_s1) * 15'd112;
    cr_g_s2 <= PROD_W'(green_s1) * 15'd94;
    cr_b_s2 <= PROD_W'(blue_s1) * 15'd18;
    // cb = -38r - 74g + 112b
    cb_r_s2 <= PROD_W'(red_s1) * 15'd38;
    cb_g_s2 <= PROD_W'(green_s1) * 15'd74;
    cb_b_s2 <= PROD_W'(blue_s1) * 15'd112;
  end

  // signed sum then floor divide by 256
  always_comb begin
    cr_sum   = ACC_W'(cr_r_s2) - ACC_W'(cr_g_s2) - ACC_W'(cr_b_s2);
    cb_sum   = ACC_W'(cb_b_s2) - ACC_W'(cb_r_s2) - ACC_W'(cb_g_s2);
    cr_shift = cr_sum >>> 8;
    cb_shift = cb_sum >>> 8;
  end

  // result always lands in 18..236, so the low byte is exact
  always_ff @(posedge clk_camera) begin
    cr_s3 <= cr_shift[CHAN_W-1:0] + 8'd128;
    cb_s3 <= cb_shift[CHAN_W-1:0] + 8'd128;
  end

  // inclusive window on each chroma channel
  always_ff @(posedge clk_camera) begin
    cr_hit_s4 <= (cr_s3 >= CR_LOW) && (cr_s3 <= CR_HIGH);
    cb_hit_s4 <= (cb_s3 >= CB_LOW) && (cb_s3 <= CB_HIGH);
  end

  // strobes walk alongside the pixel
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      valid_pipe     <= '0;
      frame_end_pipe <= '0;
    end else begin
      valid_pipe     <= {valid_pipe[DETECT_LATENCY-2:0], pixel_valid_i};
      frame_end_pipe <= {frame_end_pipe[DETECT_LATENCY-2:0], frame_end_i};
    end
  end

  // coordinates follow the same delay as the strobes
  always_ff @(posedge clk_camera) begin
    hcount_pipe[0] <= pixel_hcount_i;
    vcount_pipe[0] <= pixel_vcount_i;
    for (int i = 1; i < DETECT_LATENCY; i++) begin
      hcount_pipe[i] <= hcount_pipe[i-1];
      vcount_pipe[i] <= vcount_pipe[i-1];
    end
  end

  assign mask_o.valid     = valid_pipe[DETECT_LATENCY-1];
  assign mask_o.hcount    = hcount_pipe[DETECT_LATENCY-1];
  assign mask_o.vcount    = vcount_pipe[DETECT_LATENCY-1];
  assign mask_o.cr_hit    = cr_hit_s4;
  assign mask_o.cb_hit    = cb_hit_s4;
  assign mask_o.frame_end = frame_end_pipe[DETECT_LATENCY-1];

endmodule

//--- src/centroid_divider.sv
`timescale 1ns/10ps

module centroid_divider import tracker_pkg::*; (
  input  logic             clk_camera,
  input  logic             sys_rst_pixel,
  input  logic             start_i,
  input  logic [SUM_W-1:0] dividend_i,
  input  logic [SUM_W-1:0] divisor_i,
  output logic [SUM_W-1:0] quotient_o,
  output logic             busy_o,
  output logic             done_o
);

  localparam int CNT_W = $clog2(SUM_W + 1);

  // partial remainder stays below the divisor
  logic [SUM_W-1:0] rem_q;
  // dividend bits leave at the top while quotient bits enter at the bottom
  logic [SUM_W-1:0] quot_q;
  logic [SUM_W-1:0] div_q;
  // iterations left
  logic [CNT_W-1:0] count_q;
  // the extra msb is set when the subtract went negative
  logic [SUM_W:0]   trial;

  assign trial = {rem_q, quot_q[SUM_W-1]} - {1'b0, div_q};

  // start is only taken when idle
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      busy_o  <= 1'b0;
      done_o  <= 1'b0;
      count_q <= '0;
    end else begin
      done_o <= 1'b0;
      if (busy_o) begin
        count_q <= count_q - 1'b1;
        // last quotient bit goes in on this edge
        if (count_q == CNT_W'(1)) begin
          busy_o <= 1'b0;
          done_o <= 1'b1;
        end
      end else if (start_i) begin
        busy_o  <= 1'b1;
        count_q <= CNT_W'(SUM_W);
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (!busy_o && start_i) begin
      rem_q  <= '0;
      quot_q <= dividend_i;
      div_q  <= divisor_i;
    end else if (busy_o) begin
      // restore on a negative trial and keep the difference otherwise
      if (trial[SUM_W]) begin
        rem_q <= {rem_q[SUM_W-2:0], quot_q[SUM_W-1]};
      end else begin
        rem_q <= trial[SUM_W-1:0];
      end
      quot_q <= {quot_q[SUM_W-2:0], ~trial[SUM_W]};
    end
  end

  assign quotient_o = quot_q;

endmodule

//--- src/centroid_accum.sv
`timescale 1ns/10ps

module centroid_accum import tracker_pkg::*; #(
  // 0 tracks the cr mask, 1 tracks the cb mask
  parameter bit USE_CB = 1'b0
) (
  input  logic                clk_camera,
  input  logic                sys_rst_pixel,
  mask_if.dst                 mask_i,
  output logic [HCOUNT_W-1:0] x_o,
  output logic [VCOUNT_W-1:0] y_o,
  output logic                update_o
);

  logic             lane_hit;
  logic             pixel_hit;
  // running totals for the frame in progress
  logic [SUM_W-1:0] sum_x;
  logic [SUM_W-1:0] sum_y;
  logic [SUM_W-1:0] hit_count;
  logic             div_start;
  logic             div_busy;
  logic             div_done;
  logic [SUM_W-1:0] quot_x;
  logic [SUM_W-1:0] quot_y;
  logic             x_busy;
  logic             y_busy;
  logic             x_done;
  logic             y_done;

  assign lane_hit  = USE_CB ? mask_i.cb_hit : mask_i.cr_hit;
  assign pixel_hit = mask_i.valid && lane_hit;

  // both dividers start together and finish together
  assign div_busy = x_busy || y_busy;
  assign div_done = x_done && y_done;

  // empty frames and frames ending mid-divide are not reported
  assign div_start = mask_i.frame_end && (hit_count != '0) && !div_busy;

  // dividers latch the totals on start, so clearing here is safe
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      sum_x     <= '0;
      sum_y     <= '0;
      hit_count <= '0;
    end else if (mask_i.frame_end) begin
      sum_x     <= '0;
      sum_y     <= '0;
      hit_count <= '0;
    end else if (pixel_hit) begin
      sum_x     <= sum_x + SUM_W'(mask_i.hcount);
      sum_y     <= sum_y + SUM_W'(mask_i.vcount);
      hit_count <= hit_count + 1'b1;
    end
  end

  // mean x = sum of hcount / hits
  centroid_divider i_div_x (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (div_start),
    .dividend_i    (sum_x),
    .divisor_i     (hit_count),
    .quotient_o    (quot_x),
    .busy_o        (x_busy),
    .done_o        (x_done)
  );

  // mean y = sum of vcount / hits
  centroid_divider i_div_y (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (div_start),
    .dividend_i    (sum_y),
    .divisor_i     (hit_count),
    .quotient_o    (quot_y),
    .busy_o        (y_busy),
    .done_o        (y_done)
  );

  // a mean never exceeds the largest coordinate, so truncation is lossless
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      x_o      <= '0;
      y_o      <= '0;
      update_o <= 1'b0;
    end else begin
      update_o <= div_done;
      if (div_done) begin
        x_o <= quot_x[HCOUNT_W-1:0];
        y_o <= quot_y[VCOUNT_W-1:0];
      end
    end
  end

endmodule

//--- src/color_tracker_top.sv
`timescale 1ns/10ps

module color_tracker_top import tracker_pkg::*; #(
  parameter logic [CHAN_W-1:0] CR_LOW  = 8'd160,
  parameter logic [CHAN_W-1:0] CR_HIGH = 8'd240,
  parameter logic [CHAN_W-1:0] CB_LOW  = 8'd160,
  parameter logic [CHAN_W-1:0] CB_HIGH = 8'd240
) (
  input  logic                clk_camera,
  input  logic                sys_rst_pixel,
  // pixel stream, one pixel per valid strobe
  input  logic                pixel_valid_i,
  input  logic [HCOUNT_W-1:0] pixel_hcount_i,
  input  logic [VCOUNT_W-1:0] pixel_vcount_i,
  input  logic [15:0]         pixel_data_i,
  input  logic                frame_end_i,
  // red target centroid
  output logic [HCOUNT_W-1:0] cr_x_o,
  output logic [VCOUNT_W-1:0] cr_y_o,
  output logic                cr_update_o,
  // blue target centroid
  output logic [HCOUNT_W-1:0] cb_x_o,
  output logic [VCOUNT_W-1:0] cb_y_o,
  output logic                cb_update_o
);

  pixel565_u pixel_word;

  mask_if i_mask ();

  assign pixel_word.raw = pixel_data_i;

  chroma_detect #(
    .CR_LOW  (CR_LOW),
    .CR_HIGH (CR_HIGH),
    .CB_LOW  (CB_LOW),
    .CB_HIGH (CB_HIGH)
  ) i_detect (
    .clk_camera     (clk_camera),
    .sys_rst_pixel  (sys_rst_pixel),
    .pixel_valid_i  (pixel_valid_i),
    .pixel_hcount_i (pixel_hcount_i),
    .pixel_vcount_i (pixel_vcount_i),
    .pixel_data_i   (pixel_word),
    .frame_end_i    (frame_end_i),
    .mask_o         (i_mask)
  );

  // red tracker on the cr lane
  centroid_accum #(.USE_CB(1'b0)) i_cr_accum (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .mask_i        (i_mask),
    .x_o           (cr_x_o),
    .y_o           (cr_y_o),
    .update_o      (cr_update_o)
  );

  // blue tracker on the cb lane
  centroid_accum #(.USE_CB(1'b1)) i_cb_accum (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .mask_i        (i_mask),
    .x_o           (cb_x_o),
    .y_o           (cb_y_o),
    .update_o      (cb_update_o)
  );

endmodule

//--- tests/tb_color_tracker.sv
`timescale 1ns/10ps

module tb_color_tracker import tracker_pkg::*; ();

  // divide takes SUM_W+1 cycles plus the detector pipe, so this leaves margin
  localparam int    UPDATE_TIMEOUT = 200;
  // a frame without hits must stay quiet for the whole update timeout
  localparam int    QUIET_CYCLES   = UPDATE_TIMEOUT;
  localparam string STIM_FILE      = "tests/tracker_stimulus.txt";

  logic                clk_camera;
  logic                sys_rst_pixel;
  logic                pixel_valid_i;
  logic [HCOUNT_W-1:0] pixel_hcount_i;
  logic [VCOUNT_W-1:0] pixel_vcount_i;
  logic [15:0]         pixel_data_i;
  logic                frame_end_i;
  logic [HCOUNT_W-1:0] cr_x_o;
  logic [VCOUNT_W-1:0] cr_y_o;
  logic                cr_update_o;
  logic [HCOUNT_W-1:0] cb_x_o;
  logic [VCOUNT_W-1:0] cb_y_o;
  logic                cb_update_o;

  // index 0 is the red target on cr and index 1 the blue target on cb
  int                  update_events [2];
  int                  updates_taken [2];
  logic [HCOUNT_W-1:0] seen_x [2];
  logic [VCOUNT_W-1:0] seen_y [2];
  // last reported centroid that the outputs must keep between updates
  logic [HCOUNT_W-1:0] held_x [2];
  logic [VCOUNT_W-1:0] held_y [2];
  logic [31:0]         lcg_state;
  int                  fd;
  logic [8*96-1:0]     line_buf;
  logic [31:0]         kind;
  logic [31:0]         target;
  logic [31:0]         val_a;
  logic [31:0]         val_b;
  logic [31:0]         val_c;

  color_tracker_top i_dut (
    .clk_camera     (clk_camera),
    .sys_rst_pixel  (sys_rst_pixel),
    .pixel_valid_i  (pixel_valid_i),
    .pixel_hcount_i (pixel_hcount_i),
    .pixel_vcount_i (pixel_vcount_i),
    .pixel_data_i   (pixel_data_i),
    .frame_end_i    (frame_end_i),
    .cr_x_o         (cr_x_o),
    .cr_y_o         (cr_y_o),
    .cr_update_o    (cr_update_o),
    .cb_x_o         (cb_x_o),
    .cb_y_o         (cb_y_o),
    .cb_update_o    (cb_update_o)
  );

  initial begin
    clk_camera = 1'b0;
    forever #4 clk_camera = ~clk_camera;
  end

  // outputs are stable on the falling edge and update is high for one full cycle
  always @(negedge clk_camera) begin
    if (cr_update_o === 1'b1) begin
      seen_x[0]        <= cr_x_o;
      seen_y[0]        <= cr_y_o;
      update_events[0] <= update_events[0] + 1;
    end
    if (cb_update_o === 1'b1) begin
      seen_x[1]        <= cb_x_o;
      seen_y[1]        <= cb_y_o;
      update_events[1] <= update_events[1] + 1;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic string target_name(input int idx);
    return (idx == 1) ? "cb" : "cr";
  endfunction

  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic fail_with(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
      abort_run();
    end
  endtask

  // any update nobody asked for is a failure
  task automatic check_no_pending();
    for (int idx = 0; idx < 2; idx++) begin
      if (update_events[idx] != updates_taken[idx]) begin
        fail_with($sformatf("unexpected %s update pulse", target_name(idx)));
      end
    end
  endtask

  task automatic drive_pixel(input logic [HCOUNT_W-1:0] h, input logic [VCOUNT_W-1:0] v,
                             input logic [15:0] data);
    @(negedge clk_camera);
    pixel_valid_i  = 1'b1;
    pixel_hcount_i = h;
    pixel_vcount_i = v;
    pixel_data_i   = data;
  endtask

  // equal fields give cr = cb = 128 which lies outside both windows
  task automatic drive_filler();
    logic [31:0] rnd;
    logic [4:0]  level;
    int          count;
    count = int'((next_random() >> 16) % 32'd4);
    for (int i = 0; i < count; i++) begin
      rnd   = next_random();
      level = rnd[20:16];
      drive_pixel(HCOUNT_W'((next_random() >> 8) % 32'd1280),
                  VCOUNT_W'((next_random() >> 8) % 32'd720),
                  {level, level, 1'b0, level});
    end
  endtask

  task automatic pulse_frame_end();
    check_no_pending();
    @(negedge clk_camera);
    pixel_valid_i = 1'b0;
    frame_end_i   = 1'b1;
    @(negedge clk_camera);
    frame_end_i   = 1'b0;
  endtask

  task automatic expect_update(input int idx, input logic [31:0] exp_x,
                               input logic [31:0] exp_y);
    int cycles;
    cycles = 0;
    while (update_events[idx] == updates_taken[idx] && cycles < UPDATE_TIMEOUT) begin
      @(posedge clk_camera);
      cycles++;
    end
    if (update_events[idx] == updates_taken[idx]) begin
      fail_with($sformatf("no %s update arrived within %0d cycles of the frame end",
                          target_name(idx), UPDATE_TIMEOUT));
    end
    if (update_events[idx] - updates_taken[idx] > 1) begin
      fail_with($sformatf("more than one %s update for one frame", target_name(idx)));
    end
    check_value({target_name(idx), "_x_o"}, 32'(seen_x[idx]), exp_x);
    check_value({target_name(idx), "_y_o"}, 32'(seen_y[idx]), exp_y);
    updates_taken[idx]++;
    held_x[idx] = HCOUNT_W'(exp_x);
    held_y[idx] = VCOUNT_W'(exp_y);
  endtask

  // watch a window with no update, then check the outputs kept their value
  task automatic expect_quiet(input int idx);
    for (int c = 0; c < QUIET_CYCLES; c++) begin
      @(posedge clk_camera);
      if (update_events[idx] != updates_taken[idx]) begin
        fail_with($sformatf("%s updated for a frame without hits", target_name(idx)));
      end
    end
    @(negedge clk_camera);
    check_value({target_name(idx), "_x_o"}, 32'((idx == 1) ? cb_x_o : cr_x_o),
                32'(held_x[idx]));
    check_value({target_name(idx), "_y_o"}, 32'((idx == 1) ? cb_y_o : cr_y_o),
                32'(held_y[idx]));
  endtask

  function automatic int lane_index(input logic [31:0] tgt);
    if (tgt == "cr") return 0;
    if (tgt == "cb") return 1;
    return -1;
  endfunction

  initial begin
    sys_rst_pixel  = 1'b1;
    pixel_valid_i  = 1'b0;
    pixel_hcount_i = '0;
    pixel_vcount_i = '0;
    pixel_data_i   = '0;
    frame_end_i    = 1'b0;
    lcg_state      = 32'h6b91;
    for (int idx = 0; idx < 2; idx++) begin
      update_events[idx] = 0;
      updates_taken[idx] = 0;
      held_x[idx]        = '0;
      held_y[idx]        = '0;
    end
    repeat (16) @(posedge clk_camera);
    @(negedge clk_camera);
    sys_rst_pixel = 1'b0;
    // cleared centroids right after reset
    @(negedge clk_camera);
    check_value("cr_x_o", 32'(cr_x_o), 32'h0);
    check_value("cr_y_o", 32'(cr_y_o), 32'h0);
    check_value("cb_x_o", 32'(cb_x_o), 32'h0);
    check_value("cb_y_o", 32'(cb_y_o), 32'h0);
    check_value("cr_update_o", 32'(cr_update_o), 32'h0);
    check_value("cb_update_o", 32'(cb_update_o), 32'h0);
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      fail_with("could not open the stimulus file");
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      kind     = '0;
      target   = '0;
      if ($fgets(line_buf, fd) != 0 && $sscanf(line_buf, "%s", kind) == 1) begin
        if (kind == "p") begin
          if ($sscanf(line_buf, "%s %h %h %h", kind, val_a, val_b, val_c) != 4) begin
            fail_with("malformed pixel record in the stimulus file");
          end
          drive_filler();
          drive_pixel(HCOUNT_W'(val_a), VCOUNT_W'(val_b), val_c[15:0]);
        end else if (kind == "f") begin
          pulse_frame_end();
        end else if (kind == "e") begin
          if ($sscanf(line_buf, "%s %s %h %h", kind, target, val_a, val_b) != 4 ||
              lane_index(target) < 0) begin
            fail_with("malformed expect record in the stimulus file");
          end
          expect_update(lane_index(target), val_a, val_b);
        end else if (kind == "n") begin
          if ($sscanf(line_buf, "%s %s", kind, target) != 2 || lane_index(target) < 0) begin
            fail_with("malformed no-update record in the stimulus file");
          end
          expect_quiet(lane_index(target));
        end else if (kind != "#") begin
          fail_with("unknown record type in the stimulus file");
        end
      end
    end
    $fclose(fd);
    check_no_pending();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- tests/tracker_stimulus.txt
# p hcount vcount rgb565 = pixel, f = frame end, e cr|cb x y = expected update, n cr|cb = none
# all values hex, expected centroids are the floor mean of the hit coordinates
# pure red, cr 236 and cb 91
p 064 032 F800
p 065 032 F800
p 064 033 F800
p 067 034 F800
f
e cr 065 032
n cb
# pure blue, cb 236 and cr 110
p 1F4 12C 001F
p 1FE 12D 001F
p 1F9 131 001F
f
e cb 1F9 12E
n cr
# red and blue blobs in one frame
p 00A 014 F800
p 4B0 2BC 001F
p 00C 016 F800
p 4B3 2BD 001F
f
e cr 00B 015
e cb 4B1 2BC
# gray and black only
p 005 005 8410
p 3FF 1FF 0000
f
n cr
n cb
# 5040 gives cr 160, 4800 cr 159, 004A cb 160, 0009 cb 159
# peak chroma is 236 so the 240 bound cannot be reached from rgb565
p 0C8 064 5040
p 384 258 4800
p 0CC 06A 5040
p 12C 190 004A
p 032 032 0009
p 12D 193 004A
f
e cr 0CA 067
e cb 12C 191

//--- src.f
src/tracker_pkg.sv
src/mask_if.sv
src/chroma_detect.sv
src/centroid_divider.sv
src/centroid_accum.sv
src/color_tracker_top.sv
tests/tb_color_tracker.sv

//--- Makefile
TOP   := tb_color_tracker
BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f \
		-Mdir $(BUILD) -o $(TOP)
	@out="$$(./$(BUILD)/$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD)
